/* design/alu_pkg.sv */
// ALU execution unit shared definitions
// Sizes, opcode and control encodings, and the request, operand and writeback bundles
package alu_pkg;

    localparam int XLEN           = 32;
    localparam int INFLIGHT_COUNT = 4;                    // Bank slots, issue credits and queue depth
    localparam int ID_W           = $clog2(INFLIGHT_COUNT); // One id per bank slot
    localparam int SHAMT_W        = $clog2(XLEN);         // Shift amount comes from rs2[4:0]
    localparam int WB_CREDIT_W    = 16;                   // Holds far more grants than a consumer banks up

    // External opcode as sent by the issuer
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_SLT  = 4'd2,
        OP_SLTU = 4'd3,
        OP_AND  = 4'd4,
        OP_OR   = 4'd5,
        OP_XOR  = 4'd6,
        OP_SLL  = 4'd7,
        OP_SRL  = 4'd8,
        OP_SRA  = 4'd9
    } alu_op_e;

    // What the adder sees on its first input
    typedef enum logic [1:0] {
        LOGIC_XOR = 2'd0,
        LOGIC_OR  = 2'd1,
        LOGIC_AND = 2'd2,
        LOGIC_ADD = 2'd3
    } alu_logic_e;

    // Result mux selection
    typedef enum logic [1:0] {
        SEL_ADD_SUB = 2'd0,
        SEL_SLT     = 2'd1,
        SEL_RSHIFT  = 2'd2,
        SEL_LSHIFT  = 2'd3
    } alu_sel_e;

    // One upstream request
    typedef struct packed {
        logic [ID_W-1:0] id;
        alu_op_e         op;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
    } alu_req_t;

    // Decoded operands and prepared controls for the execute paths
    typedef struct packed {
        logic [ID_W-1:0] id;
        alu_sel_e        sel;
        alu_logic_e      logic_op;
        logic            subtract;   // Also set for both compares
        logic            is_signed;  // SLT when set, SLTU otherwise
        logic            arith;      // Sign fill on right shifts
        logic            lshift;
        logic [XLEN-1:0] in1;
        logic [XLEN-1:0] in2;
        logic [XLEN-1:0] shifter_in; // rs1, reversed for left shifts
    } alu_inputs_t;

    // One result leaving on the writeback port
    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [XLEN-1:0] rd;
    } alu_wb_t;

endpackage

/* design/alu_adder_logic.sv */
// ALU adder and logic path
// One 33-bit carry chain serves add, subtract, compares and the bitwise operations
`timescale 1ns/1ns

module alu_adder_logic (
    input  alu_pkg::alu_inputs_t      dec,
    output logic [alu_pkg::XLEN-1:0]  sum,
    output logic                      less
);

    logic [alu_pkg::XLEN:0] adder_in1;
    logic [alu_pkg::XLEN:0] adder_in2;
    logic [alu_pkg::XLEN:0] add_result; // Top bit is the sign of the extended difference
    logic                   ext1;
    logic                   ext2;

    // Sign extension only for SLT, zero extension makes bit 32 an unsigned borrow
    assign ext1 = dec.is_signed & dec.in1[alu_pkg::XLEN-1];
    assign ext2 = dec.is_signed & dec.in2[alu_pkg::XLEN-1];

    always_comb begin
        case (dec.logic_op)
            alu_pkg::LOGIC_XOR: adder_in1 = {1'b0, dec.in1 ^ dec.in2};
            alu_pkg::LOGIC_OR:  adder_in1 = {1'b0, dec.in1 | dec.in2};
            alu_pkg::LOGIC_AND: adder_in1 = {1'b0, dec.in1 & dec.in2};
            default:            adder_in1 = {ext1, dec.in1};
        endcase
    end

    // Logic results pass through the chain unchanged by adding zero
    always_comb begin
        if (dec.logic_op == alu_pkg::LOGIC_ADD) begin
            adder_in2 = {ext2, dec.in2} ^ {(alu_pkg::XLEN + 1){dec.subtract}};
        end else begin
            adder_in2 = '0;
        end
    end

    // Carry in completes the two's complement on subtract
    assign add_result = adder_in1 + adder_in2 + {{alu_pkg::XLEN{1'b0}}, dec.subtract};

    assign sum  = add_result[alu_pkg::XLEN-1:0];
    assign less = add_result[alu_pkg::XLEN]; // 33-bit difference cannot overflow

endmodule

/* design/barrel_shifter.sv */
// Logarithmic barrel shifter
// Right shifts in five stages, left shift is the bit-reversed result of a reversed input
`timescale 1ns/1ns

module barrel_shifter (
    input  logic [alu_pkg::XLEN-1:0]    shifter_in,
    input  logic [alu_pkg::SHAMT_W-1:0] shift_amount,
    input  logic                        arith,
    output logic [alu_pkg::XLEN-1:0]    rshift_result,
    output logic [alu_pkg::XLEN-1:0]    lshift_result
);

    logic [alu_pkg::XLEN-1:0] stage [alu_pkg::SHAMT_W+1];
    logic                     fill;

    // Decode clears arith for left shifts, so the reversed input never sign-fills
    assign fill     = arith & shifter_in[alu_pkg::XLEN-1];
    assign stage[0] = shifter_in;

    // Stage i moves the data right by 2**i when its amount bit is set
    for (genvar i = 0; i < alu_pkg::SHAMT_W; i++) begin : g_stage
        localparam int STEP = 1 << i;

        always_comb begin
            if (shift_amount[i]) begin
                stage[i+1] = {{STEP{fill}}, stage[i][alu_pkg::XLEN-1:STEP]};
            end else begin
                stage[i+1] = stage[i];
            end
        end
    end

    assign rshift_result = stage[alu_pkg::SHAMT_W];

    always_comb begin
        for (int i = 0; i < alu_pkg::XLEN; i++) begin
            lshift_result[i] = rshift_result[alu_pkg::XLEN-1-i]; // Undo the decode reversal
        end
    end

endmodule

/* design/alu_operand_decode.sv */
// ALU operand decode stage
// Registers an accepted request and expands its opcode into adder, shifter and mux controls
`timescale 1ns/1ns

module alu_operand_decode (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req_valid,
    input  alu_pkg::alu_req_t    req,
    output logic                 dec_valid,
    output alu_pkg::alu_inputs_t dec
);

    alu_pkg::alu_inputs_t     dec_next;
    logic [alu_pkg::XLEN-1:0] rs1_rev; // rs1 mirrored so a left shift can use the right shifter

    always_comb begin
        for (int i = 0; i < alu_pkg::XLEN; i++) begin
            rs1_rev[i] = req.rs1[alu_pkg::XLEN-1-i];
        end
    end

    // Defaults describe a plain add, each opcode only changes what differs
    always_comb begin
        dec_next          = '0;
        dec_next.id       = req.id;
        dec_next.sel      = alu_pkg::SEL_ADD_SUB;
        dec_next.logic_op = alu_pkg::LOGIC_ADD;
        dec_next.in1      = req.rs1;
        dec_next.in2      = req.rs2;
        case (req.op)
            alu_pkg::OP_SUB: dec_next.subtract = 1'b1;
            alu_pkg::OP_SLT: begin
                dec_next.sel       = alu_pkg::SEL_SLT;
                dec_next.subtract  = 1'b1;
                dec_next.is_signed = 1'b1; // Sign-extend both operands into the 33-bit difference
            end
            alu_pkg::OP_SLTU: begin
                dec_next.sel      = alu_pkg::SEL_SLT;
                dec_next.subtract = 1'b1;
            end
            alu_pkg::OP_AND: dec_next.logic_op = alu_pkg::LOGIC_AND;
            alu_pkg::OP_OR:  dec_next.logic_op = alu_pkg::LOGIC_OR;
            alu_pkg::OP_XOR: dec_next.logic_op = alu_pkg::LOGIC_XOR;
            alu_pkg::OP_SLL: begin
                dec_next.sel    = alu_pkg::SEL_LSHIFT;
                dec_next.lshift = 1'b1;
            end
            alu_pkg::OP_SRL: dec_next.sel = alu_pkg::SEL_RSHIFT;
            alu_pkg::OP_SRA: begin
                dec_next.sel   = alu_pkg::SEL_RSHIFT;
                dec_next.arith = 1'b1;
            end
            default: ; // OP_ADD and unused codes stay an add
        endcase
        dec_next.shifter_in = dec_next.lshift ? rs1_rev : req.rs1;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= req_valid; // Every request is accepted, there is no stall
        end
    end

    // Operands only load on a request so the execute paths stay quiet when idle
    always_ff @(posedge clk) begin
        if (req_valid) begin
            dec <= dec_next;
        end
    end

endmodule

/* design/alu_unit.sv */
// ALU execute unit
// Runs the adder/logic path and the shifter side by side and parks results by instruction id
`timescale 1ns/1ns

module alu_unit (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        dec_valid,
    input  alu_pkg::alu_inputs_t        dec,
    output logic                        done_valid,
    output logic [alu_pkg::ID_W-1:0]    done_id,
    input  logic [alu_pkg::ID_W-1:0]    rd_id,
    output logic [alu_pkg::XLEN-1:0]    rd_data
);

    logic [alu_pkg::XLEN-1:0] sum;
    logic                     less;
    logic [alu_pkg::XLEN-1:0] rshift_result;
    logic [alu_pkg::XLEN-1:0] lshift_result;
    logic [alu_pkg::XLEN-1:0] result;

    // One slot per id, a slot is only reused after its writeback
    logic [alu_pkg::XLEN-1:0] rd_bank [alu_pkg::INFLIGHT_COUNT];

    alu_adder_logic u_adder_logic (
        .dec  (dec),
        .sum  (sum),
        .less (less)
    );

    barrel_shifter u_barrel_shifter (
        .shifter_in    (dec.shifter_in),
        .shift_amount  (dec.in2[alu_pkg::SHAMT_W-1:0]),
        .arith         (dec.arith),
        .rshift_result (rshift_result),
        .lshift_result (lshift_result)
    );

    // Result mux
    always_comb begin
        case (dec.sel)
            alu_pkg::SEL_ADD_SUB: result = sum;
            alu_pkg::SEL_SLT:     result = {{(alu_pkg::XLEN-1){1'b0}}, less};
            alu_pkg::SEL_RSHIFT:  result = rshift_result;
            default:              result = lshift_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            rd_bank[dec.id] <= result; // Written on the edge after the request was accepted
        end
    end

    // Completion is tracked separately from the bank so the queue sees it on the write edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done_valid <= 1'b0;
            done_id    <= '0;
        end else begin
            done_valid <= 1'b0;
            if (dec_valid) begin
                done_valid <= 1'b1;
                done_id    <= dec.id;
            end
        end
    end

    assign rd_data = rd_bank[rd_id]; // Asynchronous read for the queue head

endmodule

/* design/alu_writeback_queue.sv */
// In-order writeback queue
// Holds completed ids in issue order and spends consumer credits to write them back
`timescale 1ns/1ns

module alu_writeback_queue (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        done_valid,
    input  logic [alu_pkg::ID_W-1:0]    done_id,
    output logic [alu_pkg::ID_W-1:0]    rd_id,
    input  logic [alu_pkg::XLEN-1:0]    rd_data,
    input  logic                        wb_credit,
    output logic                        wb_valid,
    output alu_pkg::alu_wb_t            wb,
    output logic                        credit_return
);

    logic [alu_pkg::ID_W-1:0]        id_fifo [alu_pkg::INFLIGHT_COUNT];
    logic [alu_pkg::ID_W-1:0]        head;
    logic [alu_pkg::ID_W-1:0]        tail;
    logic [alu_pkg::ID_W:0]          count;      // One extra bit to tell full from empty
    logic [alu_pkg::WB_CREDIT_W-1:0] wb_credits;
    logic                            pop;

    // Head is presented, popped and paid for in one cycle
    assign pop           = (count != '0) && (wb_credits != '0);
    assign wb_valid      = pop;
    assign credit_return = pop; // The freed bank slot goes straight back to the issuer
    assign rd_id         = id_fifo[head];
    assign wb.id         = rd_id;
    assign wb.rd         = rd_data;

    // Depth equals the bank size, so issue credits keep pushes from overrunning it
    always_ff @(posedge clk) begin
        if (done_valid) begin
            id_fifo[tail] <= done_id;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (done_valid) tail <= tail + 1'b1;
            if (pop)        head <= head + 1'b1;
            case ({done_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ; // Push and pop together leave the level unchanged
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_credits <= '0; // No writeback until the consumer grants room
        end else begin
            case ({wb_credit, pop})
                2'b10:   wb_credits <= wb_credits + 1'b1;
                2'b01:   wb_credits <= wb_credits - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

/* design/alu_exec_top.sv */
// ALU execution unit top level
// Decode stage, execute unit and in-order writeback queue with credit flow control
`timescale 1ns/1ns

module alu_exec_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req_valid,
    input  alu_pkg::alu_req_t req,
    output logic              credit_return,
    input  logic              wb_credit,
    output logic              wb_valid,
    output alu_pkg::alu_wb_t  wb
);

    logic                     dec_valid;
    alu_pkg::alu_inputs_t     dec;
    logic                     done_valid;
    logic [alu_pkg::ID_W-1:0] done_id;
    logic [alu_pkg::ID_W-1:0] rd_id;    // Queue head picks the bank slot
    logic [alu_pkg::XLEN-1:0] rd_data;

    alu_operand_decode u_operand_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    alu_unit u_alu_unit (
        .clk        (clk),
        .arst_n     (arst_n),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .done_valid (done_valid),
        .done_id    (done_id),
        .rd_id      (rd_id),
        .rd_data    (rd_data)
    );

    alu_writeback_queue u_writeback_queue (
        .clk           (clk),
        .arst_n        (arst_n),
        .done_valid    (done_valid),
        .done_id       (done_id),
        .rd_id         (rd_id),
        .rd_data       (rd_data),
        .wb_credit     (wb_credit),
        .wb_valid      (wb_valid),
        .wb            (wb),
        .credit_return (credit_return)
    );

endmodule

/* bench/alu_ref.svh */
// ALU reference model and random number source for the testbench
// Expected results follow the RV32I register-register integer definitions
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

// Xorshift32 step, a nonzero state never falls to zero
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Expected rd for one request
function automatic logic [31:0] alu_ref_result(input alu_pkg::alu_op_e op,
                                               input logic [31:0]     rs1,
                                               input logic [31:0]     rs2);
    logic [4:0] shamt;
    shamt = rs2[4:0]; // Register shifts only look at the low five bits
    case (op)
        alu_pkg::OP_ADD:  return rs1 + rs2;
        alu_pkg::OP_SUB:  return rs1 - rs2;
        alu_pkg::OP_SLT:  return ($signed(rs1) < $signed(rs2)) ? 32'd1 : 32'd0;
        alu_pkg::OP_SLTU: return (rs1 < rs2) ? 32'd1 : 32'd0;
        alu_pkg::OP_AND:  return rs1 & rs2;
        alu_pkg::OP_OR:   return rs1 | rs2;
        alu_pkg::OP_XOR:  return rs1 ^ rs2;
        alu_pkg::OP_SLL:  return rs1 << shamt;
        alu_pkg::OP_SRL:  return rs1 >> shamt;
        alu_pkg::OP_SRA:  return $unsigned($signed(rs1) >>> shamt); // Sign bit fills from the left
        default:          return 32'd0; // Unused codes are never issued
    endcase
endfunction

`endif

/* bench/alu_tb.sv */
// ALU execution unit testbench
// Credit-respecting stimulus, an expected-result queue and a writeback comparing process
`timescale 1ns/1ns

module alu_tb;

    logic              clk;
    logic              arst_n;
    logic              req_valid;
    alu_pkg::alu_req_t req;
    logic              credit_return;
    logic              wb_credit;
    logic              wb_valid;
    alu_pkg::alu_wb_t  wb;

    alu_pkg::alu_wb_t         exp_q [$];    // Expected writebacks in issue order
    logic [alu_pkg::ID_W-1:0] next_id;
    logic [31:0]              rand_state;
    logic [31:0]              credit_state; // Separate stream for the consumer side
    logic [31:0]              rnd;
    logic [4:0]               amt;
    alu_pkg::alu_op_e         op;
    int                       phase;        // 0 withholds writeback credits, 1 grants, 2 random
    int                       issue_credits;
    int                       issued_count;
    int                       wb_count;
    int                       returned_count;
    int                       granted_count;
    int                       base_wb;
    int                       base_ret;

    `include "alu_ref.svh"

    alu_exec_top u_alu_exec_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .wb_credit     (wb_credit),
        .wb_valid      (wb_valid),
        .wb            (wb)
    );

    always #20 clk = ~clk; // 40 ns period

    function automatic logic [31:0] next_rand();
        rand_state = xorshift32(rand_state);
        return rand_state;
    endfunction

    task automatic fail_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Simulation FAILED");
        $fatal(1, "wait timed out");
    endtask

    task automatic check_wb(input alu_pkg::alu_wb_t expected, input alu_pkg::alu_wb_t actual);
        if (actual.id !== expected.id) begin
            $display("[FAIL] t=%0t wb.id expected %0d actual %0d", $time, expected.id, actual.id);
        end
        if (actual.rd !== expected.rd) begin
            $display("[FAIL] t=%0t wb.rd expected %08h actual %08h", $time, expected.rd, actual.rd);
        end
        if (actual !== expected) begin
            $display("Simulation FAILED");
            $fatal(1, "writeback mismatch");
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    // Called on a rising edge, the request is sampled by the DUT on the next one
    task automatic issue_req(input alu_pkg::alu_op_e op_in, input logic [31:0] rs1,
                             input logic [31:0] rs2);
        int                waited;
        alu_pkg::alu_req_t r;
        alu_pkg::alu_wb_t  exp;
        waited = 0;
        while (issue_credits == 0) begin
            if (waited == 200) fail_timeout("an issue credit");
            req_valid <= 1'b0;
            @(posedge clk);
            waited++;
        end
        r.id   = next_id;
        r.op   = op_in;
        r.rs1  = rs1;
        r.rs2  = rs2;
        exp.id = next_id;
        exp.rd = alu_ref_result(op_in, rs1, rs2);
        exp_q.push_back(exp);
        req_valid <= 1'b1;
        req       <= r;
        next_id = next_id + 1'b1; // Round robin ids are free again since results retire in order
        issue_credits--;
        issued_count++;
        @(posedge clk);
    endtask

    task automatic issue_random();
        logic [31:0] rs1;
        rnd = next_rand();
        rs1 = next_rand();
        issue_req(alu_pkg::alu_op_e'(rnd % 10), rs1, next_rand());
    endtask

    task automatic idle(input int cycles);
        req_valid <= 1'b0;
        repeat (cycles) @(posedge clk);
    endtask

    // Ends once every issue credit is back, the writeback count is then checked on its own
    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        req_valid <= 1'b0;
        while (returned_count != issued_count) begin
            if (waited == limit) fail_timeout("outstanding credit returns");
            @(posedge clk);
            waited++;
        end
    endtask

    // Consumer never grants more than there are requests, so nothing stays banked in the DUT
    always @(posedge clk) begin
        credit_state = xorshift32(credit_state);
        if (arst_n && granted_count < issued_count &&
            (phase == 1 || (phase == 2 && credit_state[7]))) begin
            wb_credit <= 1'b1;
            granted_count++;
        end else begin
            wb_credit <= 1'b0;
        end
    end

    // Outputs are compared on the falling edge where they have settled
    always @(negedge clk) begin
        if (arst_n && credit_return) begin
            issue_credits++;
            returned_count++;
        end
        if (arst_n && wb_valid) begin
            if (exp_q.size() == 0) begin
                $display("A writeback with id %0d arrived with nothing outstanding", wb.id);
                $display("Simulation FAILED");
                $fatal(1, "unexpected writeback");
            end else begin
                check_wb(exp_q.pop_front(), wb);
                wb_count++;
            end
        end
    end

    initial begin
        clk            = 1'b0;
        arst_n         = 1'b0;
        req_valid      = 1'b0;
        req            = '0;
        wb_credit      = 1'b0;
        next_id        = '0;
        rand_state     = 32'd6;
        credit_state   = ~32'd6;
        phase          = 0;
        issue_credits  = alu_pkg::INFLIGHT_COUNT;
        issued_count   = 0;
        wb_count       = 0;
        returned_count = 0;
        granted_count  = 0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        // Nothing may leave until the consumer grants a credit
        issue_req(alu_pkg::OP_ADD, 32'd5, 32'd7);
        idle(10);
        check_count("wb_valid pulses", 0, wb_count);
        check_count("credit_return pulses", 0, returned_count);
        phase = 1;
        wait_drain(50);
        check_count("wb_valid pulses", returned_count, wb_count);

        issue_req(alu_pkg::OP_ADD, 32'hFFFF_FFFF, 32'd1); // Wraps to zero
        issue_req(alu_pkg::OP_ADD, 32'h7FFF_FFFF, 32'd1);
        issue_req(alu_pkg::OP_SUB, 32'd0, 32'd1);         // Wraps to all ones
        issue_req(alu_pkg::OP_SUB, 32'h8000_0000, 32'd1);
        for (int n = 0; n < 15; n++) begin
            op  = (n % 5 == 0) ? alu_pkg::OP_ADD : (n % 5 == 1) ? alu_pkg::OP_SUB :
                  (n % 5 == 2) ? alu_pkg::OP_AND : (n % 5 == 3) ? alu_pkg::OP_OR : alu_pkg::OP_XOR;
            rnd = next_rand();
            issue_req(op, rnd, next_rand());
        end

        // Corner pairs where signed and unsigned answers disagree
        rnd = next_rand();
        for (int s = 0; s < 2; s++) begin
            op = (s == 0) ? alu_pkg::OP_SLT : alu_pkg::OP_SLTU;
            issue_req(op, 32'h8000_0000, 32'd1);
            issue_req(op, 32'd1, 32'h8000_0000);
            issue_req(op, rnd, rnd);
            issue_req(op, 32'hFFFF_FFFF, 32'd0);
            issue_req(op, 32'd0, 32'hFFFF_FFFF);
        end

        for (int k = 0; k < 3; k++) begin
            for (int a = 0; a < 4; a++) begin
                rnd = next_rand();
                amt = (a == 0) ? 5'd0 : (a == 1) ? 5'd1 : (a == 2) ? 5'd31 : rnd[4:0];
                op  = (k == 0) ? alu_pkg::OP_SLL : (k == 1) ? alu_pkg::OP_SRL : alu_pkg::OP_SRA;
                issue_req(op, 32'h8765_4321, {rnd[31:5], amt}); // Upper rs2 bits are ignored
                issue_req(op, 32'h1234_5678, {rnd[31:5], amt});
            end
        end
        wait_drain(100);

        // Fill every bank slot with no writeback credit and watch the unit hold
        phase    = 0;
        base_wb  = wb_count;
        base_ret = returned_count;
        for (int n = 0; n < alu_pkg::INFLIGHT_COUNT; n++) issue_random();
        check_count("issue credits", 0, issue_credits);
        idle(20);
        check_count("wb_valid pulses", base_wb, wb_count);
        check_count("credit_return pulses", base_ret, returned_count);
        phase = 1;
        wait_drain(50);
        check_count("credit_return pulses", wb_count, returned_count);

        phase = 2;
        for (int n = 0; n < 300; n++) issue_random();
        wait_drain(2000);
        check_count("written back", issued_count, wb_count);
        check_count("credit returns", wb_count, returned_count);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* all.f */
+incdir+bench
design/alu_pkg.sv
design/alu_adder_logic.sv
design/barrel_shifter.sv
design/alu_operand_decode.sv
design/alu_unit.sv
design/alu_writeback_queue.sv
design/alu_exec_top.sv
bench/alu_tb.sv
